/* code_packer.sv */
module code_packer #(
  parameter int CACHE_LINE = 128,
  parameter int WORD_SIZE  = 64
) (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  input  logic                               i_valid,
  input  logic                               i_first,
  input  logic                               i_last,
  input  logic [CACHE_LINE-1:0]              i_raw_line,
  input  cpack_pkg::word_code_t              i_code1,
  input  cpack_pkg::word_code_t              i_code2,
  input  logic [cpack_pkg::LINE_LEN_W-1:0]   i_shift_amount,
  input  logic                               i_stop_flag,
  input  logic                               i_output_flag,
  input  logic                               i_compressed_flag,
  output logic                               o_valid,
  output cpack_pkg::cline_out_t              o_line
);

  localparam int BUF_W = CACHE_LINE + WORD_SIZE + 4; // Room for one overrunning pair
  localparam int CW    = cpack_pkg::CODE_W;
  localparam int LW    = cpack_pkg::LINE_LEN_W;

  logic [BUF_W-1:0]      acc_q;     // Codes of earlier pairs, MSB first
  logic [CACHE_LINE-1:0] raw_q;
  logic [BUF_W-1:0]      base;
  logic [BUF_W-1:0]      ext1;
  logic [BUF_W-1:0]      ext2;
  logic [BUF_W-1:0]      pack_buf;
  logic [LW-1:0]         pos2;      // Start of the second code
  logic [LW-1:0]         final_len;
  logic [CACHE_LINE-1:0] raw_sel;

  assign base = i_first ? '0 : acc_q;
  assign pos2 = i_shift_amount + LW'(i_code1.len);

  assign ext1 = {i_code1.bits, {(BUF_W-CW){1'b0}}} >> i_shift_amount;
  assign ext2 = {i_code2.bits, {(BUF_W-CW){1'b0}}} >> pos2;

  assign pack_buf  = i_stop_flag ? base : (base | ext1 | ext2);
  assign final_len = pos2 + LW'(i_code2.len);
  assign raw_sel   = i_first ? i_raw_line : raw_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & i_output_flag;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && !i_last) begin
      acc_q <= pack_buf;
    end
    if (i_valid && i_first) begin
      raw_q <= i_raw_line; // Source line may change before the last pair
    end
    if (i_valid && i_output_flag) begin
      o_line.compressed <= i_compressed_flag;
      if (i_compressed_flag) begin
        o_line.len     <= final_len;
        o_line.payload <= pack_buf[BUF_W-1 -: CACHE_LINE];
      end else begin
        o_line.len     <= LW'(CACHE_LINE);
        o_line.payload <= raw_sel;
      end
    end
  end

endmodule

/* cpack_compressor.f */
cpack_pkg.sv
pattern_matcher.sv
word_length_generator.sv
length_accumulator.sv
length_generation.sv
code_packer.sv
cpack_compressor.sv
tb_clk_gen.sv
cpack_monitor.sv
cpack_compressor_chk.sv
tb_cpack_compressor.sv

/* cpack_compressor.sv */
module cpack_compressor #(
  parameter int CACHE_LINE = cpack_pkg::CACHE_LINE,
  parameter int WORD_SIZE  = cpack_pkg::WORD_SIZE,
  parameter int CREDITS    = 2
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  logic [CACHE_LINE-1:0]  i_line,   // Word 0 in the upper bits
  output logic                   o_ready,
  output logic                   o_valid,
  output cpack_pkg::cline_out_t  o_line,
  input  logic                   i_credit
);

  localparam int CRD_W = $clog2(CREDITS + 1);

  logic                  accept;
  logic [CACHE_LINE-1:0] line_q;
  logic                  pair0_q;   // Pair 0 on the matcher input
  logic                  pair1_q;   // Pair 1 on the matcher input
  logic [CRD_W-1:0]      crd_q;
  logic [CRD_W-1:0]      crd_next;
  logic                  pair_valid;
  logic [WORD_SIZE-1:0]  pair_words;

  logic                                  match_valid;
  cpack_pkg::pair_match_t                match;
  cpack_pkg::word_code_t                 code1;
  cpack_pkg::word_code_t                 code2;
  logic [cpack_pkg::LINE_LEN_W-1:0]      shift_amount;
  logic                                  stop_flag;
  logic                                  output_flag;
  logic                                  compressed_flag;
  logic                                  pk_valid;
  cpack_pkg::cline_out_t                 pk_line;

  assign accept   = i_valid & o_ready;
  assign crd_next = crd_q + CRD_W'(i_credit) - CRD_W'(accept); // Reserve on accept

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      crd_q   <= CRD_W'(CREDITS);
      o_ready <= 1'b0;
      pair0_q <= 1'b0;
      pair1_q <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      crd_q   <= crd_next;
      o_ready <= ~accept & (crd_next != '0); // Low in the cycle after an accept
      pair0_q <= accept;
      pair1_q <= pair0_q;
      o_valid <= pk_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      line_q <= i_line;
    end
    if (pk_valid) begin
      o_line <= pk_line;
    end
  end

  // Pair select
  assign pair_valid = pair0_q | pair1_q;
  assign pair_words = pair0_q ? line_q[CACHE_LINE-1 -: WORD_SIZE]
                              : line_q[CACHE_LINE-WORD_SIZE-1 -: WORD_SIZE];

  pattern_matcher u_pattern_matcher (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_pair_valid  (pair_valid),
    .i_first       (pair0_q),
    .i_last        (pair1_q),
    .i_words       (pair_words),
    .o_match_valid (match_valid),
    .o_match       (match)
  );

  length_generation #(
    .CACHE_LINE (CACHE_LINE),
    .WORD_SIZE  (WORD_SIZE)
  ) u_length_generation (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_match_valid     (match_valid),
    .i_match           (match),
    .o_code1           (code1),
    .o_code2           (code2),
    .o_total_length    (),             // Consumed inside by the accumulator
    .o_shift_amount    (shift_amount),
    .o_stop_flag       (stop_flag),
    .o_output_flag     (output_flag),
    .o_compressed_flag (compressed_flag)
  );

  code_packer #(
    .CACHE_LINE (CACHE_LINE),
    .WORD_SIZE  (WORD_SIZE)
  ) u_code_packer (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_valid           (match_valid),
    .i_first           (match.first),
    .i_last            (match.last),
    .i_raw_line        (line_q),
    .i_code1           (code1),
    .i_code2           (code2),
    .i_shift_amount    (shift_amount),
    .i_stop_flag       (stop_flag),
    .i_output_flag     (output_flag),
    .i_compressed_flag (compressed_flag),
    .o_valid           (pk_valid),
    .o_line            (pk_line)
  );

endmodule

/* cpack_compressor_chk.sv */
module cpack_compressor_chk #(
  parameter int CREDITS = 2
) (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_valid,
  input logic i_ready,
  input logic i_out_valid,
  input logic i_credit
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0; // Assertion failures so far

  logic accept;
  int   free_slots; // Receiver slots left by accepts and returned credits

  assign accept = i_valid & i_ready;

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      free_slots <= CREDITS;
    end else begin
      free_slots <= free_slots + int'(i_credit) - int'(accept);
    end
  end

  // Output register is loaded on edge 4 and sampled on tick 5
  a_out_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    accept |-> ##5 $rose(i_out_valid))
    else begin
      fail_count++;
      $error("o_valid did not rise 4 cycles after an accepted line");
    end

  a_credit_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    accept |-> free_slots > 0)
    else begin
      fail_count++;
      $error("Line accepted with no credit left");
    end

  a_ready_gap : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    accept |=> !i_ready)
    else begin
      fail_count++;
      $error("o_ready stayed high in the cycle after an accept");
    end

endmodule

/* cpack_monitor.sv */
module cpack_monitor #(
  parameter int CREDITS = 2
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_valid,
  input  logic [cpack_pkg::CACHE_LINE-1:0]    i_line,
  input  logic                                i_ready,
  input  logic                                i_out_valid,
  input  cpack_pkg::cline_out_t               i_out_line,
  input  logic                                i_credit,
  input  logic                                i_exp_compressed,
  input  logic [cpack_pkg::LINE_LEN_W-1:0]    i_exp_len,
  input  logic [31:0]                         i_test_id,
  output int                                  o_done,
  output int                                  o_passed,
  output int                                  o_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0]  id;
    logic         compressed;
    logic [7:0]   len;
    logic [127:0] payload;
  } expect_t;

  expect_t exp_q [$];   // Lines accepted, oldest first
  int      credits;     // Receiver slots still free

  // Lowest dictionary entry whose upper bits equal the word, -1 if none
  function automatic int lowest_match(input logic [31:0] w, input bit use_dict,
                                      input logic [31:0] d0, input logic [31:0] d1,
                                      input int bits);
    int sh;
    sh = 32 - bits;
    if (!use_dict) return -1;
    if ((d0 >> sh) == (w >> sh)) return 0;
    if ((d1 >> sh) == (w >> sh)) return 1;
    return -1;
  endfunction

  // Code value right aligned, with its length
  function automatic void code_word(input logic [31:0] w, input bit use_dict,
                                    input logic [31:0] d0, input logic [31:0] d1,
                                    output logic [33:0] val, output int len);
    int full_hit;
    int hi24_hit;
    int hi16_hit;
    full_hit = lowest_match(w, use_dict, d0, d1, 32);
    hi24_hit = lowest_match(w, use_dict, d0, d1, 24);
    hi16_hit = lowest_match(w, use_dict, d0, d1, 16);
    if (w == '0) begin
      val = 34'd0;
      len = 2;
    end else if (full_hit >= 0) begin
      val = 34'({2'b10, full_hit[0]});
      len = 3;
    end else if (w[31:8] == '0) begin
      val = 34'({4'b1101, w[7:0]});
      len = 12;
    end else if (hi24_hit >= 0) begin
      val = 34'({4'b1110, hi24_hit[0], w[7:0]});
      len = 13;
    end else if (hi16_hit >= 0) begin
      val = 34'({4'b1100, hi16_hit[0], w[15:0]});
      len = 21;
    end else begin
      val = {2'b01, w};
      len = 34;
    end
  endfunction

  function automatic expect_t model_line(input logic [127:0] ln, input logic [31:0] id);
    logic [31:0]  w [4];
    logic [143:0] stream;
    logic [33:0]  val;
    int           len;
    int           total;
    int           k;
    expect_t      e;
    stream = '0;
    total  = 0;
    for (k = 0; k < 4; k++) w[k] = ln[127-32*k -: 32]; // Word 0 on top
    for (k = 0; k < 4; k++) begin
      code_word(w[k], k >= 2, w[0], w[1], val, len); // Pair 1 sees words 0 and 1
      stream = (stream << len) | 144'(val);
      total  += len;
    end
    e.id         = id;
    e.compressed = (total < 128);
    e.len        = e.compressed ? 8'(total) : 8'd128;
    e.payload    = e.compressed ? 128'(stream << (128 - total)) : ln;
    return e;
  endfunction

  task automatic compare_line(input expect_t e);
    int bad;
    bad = 0;
    if (i_out_line.compressed !== e.compressed) begin
      $display("[FAIL] test %0d: o_line.compressed expected 0x%0h got 0x%0h",
               e.id, e.compressed, i_out_line.compressed);
      bad++;
    end
    if (i_out_line.len !== e.len) begin
      $display("[FAIL] test %0d: o_line.len expected 0x%0h got 0x%0h",
               e.id, e.len, i_out_line.len);
      bad++;
    end
    if (i_out_line.payload !== e.payload) begin
      $display("[FAIL] test %0d: o_line.payload expected 0x%032h got 0x%032h",
               e.id, e.payload, i_out_line.payload);
      bad++;
    end
    o_errors += bad;
    o_done++;
    if (bad == 0) begin
      o_passed++;
      $display("test %0d: ok, compressed %0d, %0d bits", e.id, e.compressed, e.len);
    end else begin
      $display("test %0d: %0d field mismatches", e.id, bad);
    end
  endtask

  // Negedge sampling, inputs and outputs are both settled here
  always @(negedge i_clk) begin : watch
    expect_t e;
    if (!i_rst_n) begin
      credits  = CREDITS;
      o_done   = 0;
      o_passed = 0;
      o_errors = 0;
      exp_q.delete();
    end else begin
      if (i_out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Output line appeared with no line outstanding");
          o_errors++;
        end else begin
          compare_line(exp_q.pop_front());
        end
      end
      if (i_ready === 1'b1 && credits == 0) begin
        $display("o_ready is high while the receiver has no free slot");
        o_errors++;
      end
      if (i_valid === 1'b1 && i_ready === 1'b1) begin
        e = model_line(i_line, i_test_id);
        if (e.compressed !== i_exp_compressed || e.len !== i_exp_len) begin
          $display("Test %0d table entry disagrees with the coding rules", i_test_id);
          o_errors++;
        end
        e.compressed = i_exp_compressed;
        e.len        = i_exp_len;
        exp_q.push_back(e);
        credits--;
      end
      if (i_credit === 1'b1) credits++;
    end
  end

endmodule

/* cpack_pkg.sv */
package cpack_pkg;

  // Line and word geometry
  localparam int CACHE_LINE = 128;          // Bits per cache line
  localparam int WORD_SIZE  = 64;           // Bits per word pair
  localparam int WORD_BITS  = 32;           // Bits per word
  localparam int CODE_W     = WORD_BITS + 2; // Longest code, XXXX

  // Length field widths
  localparam int LEN_W      = 6;            // One code, max 34
  localparam int TOTAL_W    = 7;            // One pair, max 68
  localparam int LINE_LEN_W = 8;            // One line, max 136

  // Word patterns in match priority order
  typedef enum logic [2:0] {
    ZZZZ = 3'd0, // All zero
    MMMM = 3'd1, // Full dictionary match
    ZZZX = 3'd2, // Upper 24 bits zero
    MMMX = 3'd3, // Upper 24 bits match
    MMXX = 3'd4, // Upper 16 bits match
    XXXX = 3'd5  // No match
  } cpack_pat_e;

  // Code prefixes
  localparam logic [1:0] PFX_ZZZZ = 2'b00;
  localparam logic [1:0] PFX_XXXX = 2'b01;
  localparam logic [1:0] PFX_MMMM = 2'b10;
  localparam logic [3:0] PFX_MMXX = 4'b1100;
  localparam logic [3:0] PFX_ZZZX = 4'b1101;
  localparam logic [3:0] PFX_MMMX = 4'b1110;

  // Full code lengths, prefix included
  localparam logic [LEN_W-1:0] LEN_ZZZZ = 6'd2;
  localparam logic [LEN_W-1:0] LEN_XXXX = 6'd34;
  localparam logic [LEN_W-1:0] LEN_MMMM = 6'd3;
  localparam logic [LEN_W-1:0] LEN_MMXX = 6'd21;
  localparam logic [LEN_W-1:0] LEN_ZZZX = 6'd12;
  localparam logic [LEN_W-1:0] LEN_MMMX = 6'd13;

  // Match result for one word
  typedef struct packed {
    cpack_pat_e             pat;
    logic                   idx;  // Dictionary entry that matched
    logic [WORD_BITS-1:0]   word;
  } word_match_t;

  // Match result for one pair, w0 is the earlier word
  typedef struct packed {
    word_match_t w0;
    word_match_t w1;
    logic        first; // Pair 0 of the line
    logic        last;  // Final pair of the line
  } pair_match_t;

  // Code bits are left aligned, unused low bits zero
  typedef struct packed {
    logic [CODE_W-1:0] bits;
    logic [LEN_W-1:0]  len;
  } word_code_t;

  typedef struct packed {
    logic                   compressed;
    logic [LINE_LEN_W-1:0]  len;
    logic [CACHE_LINE-1:0]  payload;
  } cline_out_t;

endpackage

/* length_accumulator.sv */
module length_accumulator #(
  parameter int CACHE_LINE = 128,
  parameter int WORD_SIZE  = 64
) (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  input  logic                               i_valid,
  input  logic                               i_first,
  input  logic                               i_last,
  input  logic [cpack_pkg::TOTAL_W-1:0]      i_total_length,
  output logic [cpack_pkg::LINE_LEN_W-1:0]   o_shift_amount,
  output logic                               o_stop_flag,
  output logic                               o_output_flag,
  output logic                               o_compressed_flag
);

  // Count can overrun the line by at most one worst case pair
  localparam int CNT_W = $clog2(CACHE_LINE + WORD_SIZE + 5);

  logic [CNT_W-1:0] count_q;    // Bits packed by earlier pairs
  logic             stop_q;     // Line already full
  logic [CNT_W-1:0] base;
  logic [CNT_W-1:0] next_count;

  assign base       = i_first ? '0 : count_q; // First pair restarts the line
  assign next_count = base + CNT_W'(i_total_length);

  assign o_shift_amount    = cpack_pkg::LINE_LEN_W'(base);
  assign o_stop_flag       = i_valid & ~i_first & stop_q;
  assign o_output_flag     = i_valid & i_last;
  assign o_compressed_flag = i_valid & i_last & (next_count < CNT_W'(CACHE_LINE));

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      count_q <= '0;
      stop_q  <= 1'b0;
    end else if (i_valid) begin
      count_q <= next_count;
      stop_q  <= (next_count >= CNT_W'(CACHE_LINE));
    end
  end

endmodule

/* length_generation.sv */
module length_generation #(
  parameter int CACHE_LINE = 128,
  parameter int WORD_SIZE  = 64
) (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  input  logic                               i_match_valid,
  input  cpack_pkg::pair_match_t             i_match,
  output cpack_pkg::word_code_t              o_code1,
  output cpack_pkg::word_code_t              o_code2,
  output logic [cpack_pkg::TOTAL_W-1:0]      o_total_length,
  output logic [cpack_pkg::LINE_LEN_W-1:0]   o_shift_amount,
  output logic                               o_stop_flag,
  output logic                               o_output_flag,
  output logic                               o_compressed_flag
);

  word_length_generator u_word_length_generator1 (
    .i_match (i_match.w0),
    .o_code  (o_code1)
  );

  word_length_generator u_word_length_generator2 (
    .i_match (i_match.w1),
    .o_code  (o_code2)
  );

  // Pair total feeds the running line count
  assign o_total_length = cpack_pkg::TOTAL_W'(o_code1.len)
                        + cpack_pkg::TOTAL_W'(o_code2.len);

  length_accumulator #(
    .CACHE_LINE (CACHE_LINE),
    .WORD_SIZE  (WORD_SIZE)
  ) u_length_accumulator (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_valid           (i_match_valid),
    .i_first           (i_match.first),
    .i_last            (i_match.last),
    .i_total_length    (o_total_length),
    .o_shift_amount    (o_shift_amount),
    .o_stop_flag       (o_stop_flag),
    .o_output_flag     (o_output_flag),
    .o_compressed_flag (o_compressed_flag)
  );

endmodule

/* pattern_matcher.sv */
module pattern_matcher (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_pair_valid,
  input  logic                          i_first,
  input  logic                          i_last,
  input  logic [cpack_pkg::WORD_SIZE-1:0] i_words, // Earlier word in upper half
  output logic                          o_match_valid,
  output cpack_pkg::pair_match_t        o_match
);

  localparam int WB = cpack_pkg::WORD_BITS;

  logic [WB-1:0] dict_q [2]; // Entry 0 is the earlier word
  logic [1:0]    dict_v_q;
  logic [1:0]    dict_use;   // Entries visible to this pair
  logic [WB-1:0] word0;
  logic [WB-1:0] word1;
  cpack_pkg::word_match_t m0;
  cpack_pkg::word_match_t m1;

  function automatic cpack_pkg::word_match_t classify(
    input logic [WB-1:0] w,
    input logic [1:0]    v,
    input logic [WB-1:0] d0,
    input logic [WB-1:0] d1
  );
    cpack_pkg::word_match_t m;
    logic [1:0] full;
    logic [1:0] hi24;
    logic [1:0] hi16;
    full = {v[1] & (d1 == w), v[0] & (d0 == w)};
    hi24 = {v[1] & (d1[WB-1:8] == w[WB-1:8]), v[0] & (d0[WB-1:8] == w[WB-1:8])};
    hi16 = {v[1] & (d1[WB-1:16] == w[WB-1:16]), v[0] & (d0[WB-1:16] == w[WB-1:16])};
    m.word = w;
    m.idx  = 1'b0;
    m.pat  = cpack_pkg::XXXX;
    if (w == '0) begin
      m.pat = cpack_pkg::ZZZZ;
    end else if (|full) begin
      m.pat = cpack_pkg::MMMM;
      m.idx = ~full[0];           // Lowest index wins
    end else if (w[WB-1:8] == '0) begin
      m.pat = cpack_pkg::ZZZX;
    end else if (|hi24) begin
      m.pat = cpack_pkg::MMMX;
      m.idx = ~hi24[0];
    end else if (|hi16) begin
      m.pat = cpack_pkg::MMXX;
      m.idx = ~hi16[0];
    end
    return m;
  endfunction

  assign word0    = i_words[cpack_pkg::WORD_SIZE-1 -: WB];
  assign word1    = i_words[WB-1:0];
  assign dict_use = dict_v_q & {2{~i_first}}; // Pair 0 sees an empty dictionary

  assign m0 = classify(word0, dict_use, dict_q[0], dict_q[1]);
  assign m1 = classify(word1, dict_use, dict_q[0], dict_q[1]);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      dict_v_q      <= 2'b00;
      o_match_valid <= 1'b0;
    end else begin
      o_match_valid <= i_pair_valid;
      if (i_pair_valid && i_first) begin
        dict_v_q <= 2'b11;
      end else if (i_pair_valid && i_last) begin
        dict_v_q <= 2'b00; // Line done, nothing carries over
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pair_valid) begin
      o_match <= '{w0: m0, w1: m1, first: i_first, last: i_last};
      if (i_first) begin
        dict_q[0] <= word0;
        dict_q[1] <= word1;
      end
    end
  end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #0.5 o_rst_n = 1'b1; // Released off the edge like the other inputs
  end

endmodule

/* tb_cpack_compressor.sv */
module tb_cpack_compressor;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CREDITS     = 2;
  localparam int NUM_TESTS   = 12;
  localparam int TIMEOUT     = NUM_TESTS * 12 + 50;
  localparam int STALL_LIMIT = 12;  // Cycles the receiver sits on its credits

  typedef struct packed {
    logic [127:0] line;       // Word 0 in the upper bits
    logic         compressed;
    logic [7:0]   len;
    logic         b2b;        // Back to back with credits withheld
  } vector_t;

  localparam vector_t VECTORS [NUM_TESTS] = '{
    '{128'h00000000_00000000_00000000_00000000, 1'b1, 8'd8,   1'b0}, // Four ZZZZ
    '{128'ha5a51234_0badf00d_a5a51234_0badf00d, 1'b1, 8'd74,  1'b0}, // Pair 1 repeats pair 0
    '{128'h12345678_000000ab_123456ff_1234abcd, 1'b1, 8'd80,  1'b0}, // XXXX ZZZX MMMX MMXX
    '{128'h00000042_00000042_00000042_00000043, 1'b1, 8'd39,  1'b0}, // Priority order
    '{128'h11112222_33334444_33334455_33339999, 1'b1, 8'd102, 1'b0}, // Index 1 partials
    '{128'haaaa1111_bbbb2222_cccc3333_aaaaffff, 1'b1, 8'd123, 1'b0}, // Just under the line
    '{128'hdeadbeef_cafef00d_13579bdf_2468ace0, 1'b0, 8'd128, 1'b0}, // 136 bits so sent raw
    '{128'h87654321_87654321_87654321_00000000, 1'b1, 8'd73,  1'b0}, // Equal pair 0 words
    '{128'h00000001_00000002_00000001_00000000, 1'b1, 8'd29,  1'b1},
    '{128'hffffffff_ffffff00_ffffffff_ffff0000, 1'b1, 8'd92,  1'b1},
    '{128'h01234567_89abcdef_00000000_89abcdef, 1'b1, 8'd73,  1'b1},
    '{128'h55555555_66666666_77777777_88888888, 1'b0, 8'd128, 1'b1}
  };

  logic                  clk;
  logic                  rst_n;
  logic                  valid;
  logic [127:0]          in_line;
  logic                  ready;
  logic                  out_valid;
  cpack_pkg::cline_out_t out_line;
  logic                  credit;
  logic                  exp_compressed;
  logic [7:0]            exp_len;
  logic [31:0]           test_id;
  logic                  withhold;   // Receiver keeps its credits
  logic [2:0]            ret_pipe;
  int                    owed;
  int                    seed;
  int                    cycles;
  int                    done;
  int                    passed;
  int                    errors;

  tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(10)) u_tb_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  cpack_compressor #(
    .CACHE_LINE (cpack_pkg::CACHE_LINE),
    .WORD_SIZE  (cpack_pkg::WORD_SIZE),
    .CREDITS    (CREDITS)
  ) u_cpack_compressor (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_valid  (valid),
    .i_line   (in_line),
    .o_ready  (ready),
    .o_valid  (out_valid),
    .o_line   (out_line),
    .i_credit (credit)
  );

  bind cpack_compressor cpack_compressor_chk #(.CREDITS(CREDITS)) u_cpack_compressor_chk (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_ready     (o_ready),
    .i_out_valid (o_valid),
    .i_credit    (i_credit)
  );

  cpack_monitor #(.CREDITS(CREDITS)) u_cpack_monitor (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_valid          (valid),
    .i_line           (in_line),
    .i_ready          (ready),
    .i_out_valid      (out_valid),
    .i_out_line       (out_line),
    .i_credit         (credit),
    .i_exp_compressed (exp_compressed),
    .i_exp_len        (exp_len),
    .i_test_id        (test_id),
    .o_done           (done),
    .o_passed         (passed),
    .o_errors         (errors)
  );

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  task automatic send_line(input int idx);
    int waited;
    waited = 0;
    while (ready !== 1'b1) begin
      step();
      waited++;
      if (withhold && waited == STALL_LIMIT) withhold <= 1'b0; // Receiver frees its slots
    end
    valid          = 1'b1;
    in_line        = VECTORS[idx].line;
    exp_compressed = VECTORS[idx].compressed;
    exp_len        = VECTORS[idx].len;
    test_id        = idx;
    step();
    valid = 1'b0;
  endtask

  // Receiver returns one credit 3 cycles after each output line
  initial begin : receiver
    credit   = 1'b0;
    ret_pipe = '0;
    owed     = 0;
    forever begin
      step();
      ret_pipe = {ret_pipe[1:0], out_valid === 1'b1};
      if (withhold) begin
        credit = 1'b0;
        owed   += ret_pipe[2];
      end else if (ret_pipe[2]) begin
        credit = 1'b1;
      end else if (owed > 0) begin
        credit = 1'b1;
        owed--;
      end else begin
        credit = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : driver
    int          gap;
    int          i;
    int unsigned asserts;
    valid          = 1'b0;
    in_line        = '0;
    exp_compressed = 1'b0;
    exp_len        = '0;
    test_id        = '0;
    withhold       = 1'b0;
    seed           = 32'h6bbc;
    wait (rst_n === 1'b1);
    step();
    for (i = 0; i < NUM_TESTS; i++) begin
      if (VECTORS[i].b2b) begin
        if (i > 0 && !VECTORS[i-1].b2b) begin
          while (done < i) step(); // All credits home before the burst
          repeat (6) step();
        end
        withhold <= 1'b1;
      end else begin
        gap = $random(seed) & 3;
        repeat (gap) step();
      end
      send_line(i);
    end
    withhold <= 1'b0;
    while (done < NUM_TESTS) step();
    repeat (8) step(); // Catch any stray output
    asserts = u_cpack_compressor.u_cpack_compressor_chk.fail_count;
    $display("Summary: %0d tests, %0d ok, %0d failed, %0d check errors, %0d assertion failures",
             NUM_TESTS, passed, NUM_TESTS - passed, errors, asserts);
    if (errors == 0 && asserts == 0 && passed == NUM_TESTS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* word_length_generator.sv */
module word_length_generator (
  input  cpack_pkg::word_match_t i_match,
  output cpack_pkg::word_code_t  o_code
);

  localparam int CW = cpack_pkg::CODE_W;

  always_comb begin
    case (i_match.pat)
      cpack_pkg::ZZZZ: begin
        o_code.bits = {cpack_pkg::PFX_ZZZZ, {(CW-2){1'b0}}};
        o_code.len  = cpack_pkg::LEN_ZZZZ;
      end
      cpack_pkg::MMMM: begin
        // Prefix and index only
        o_code.bits = {cpack_pkg::PFX_MMMM, i_match.idx, {(CW-3){1'b0}}};
        o_code.len  = cpack_pkg::LEN_MMMM;
      end
      cpack_pkg::ZZZX: begin
        o_code.bits = {cpack_pkg::PFX_ZZZX, i_match.word[7:0], {(CW-12){1'b0}}};
        o_code.len  = cpack_pkg::LEN_ZZZX;
      end
      cpack_pkg::MMMX: begin
        o_code.bits = {cpack_pkg::PFX_MMMX, i_match.idx, i_match.word[7:0],
                       {(CW-13){1'b0}}};
        o_code.len  = cpack_pkg::LEN_MMMX;
      end
      cpack_pkg::MMXX: begin
        o_code.bits = {cpack_pkg::PFX_MMXX, i_match.idx, i_match.word[15:0],
                       {(CW-21){1'b0}}};
        o_code.len  = cpack_pkg::LEN_MMXX;
      end
      default: begin // XXXX, whole word follows
        o_code.bits = {cpack_pkg::PFX_XXXX, i_match.word};
        o_code.len  = cpack_pkg::LEN_XXXX;
      end
    endcase
  end

endmodule
